// ==== tb.f ====
+incdir+.
mem_pkg.sv
block_if.sv
cache_ctrl.sv
cache_array.sv
block_mem.sv
load_store_unit.sv
mem_stage_top.sv
tb_mem_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the memory stage testbench with Verilator, runs it and checks sim.log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_mem_stage \
    --Mdir obj_dir -o sim_mem_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_mem_stage > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
    exit 0
fi
exit 1

// ==== tb_mem_stage.sv ====
// Testbench for the memory stage: directed and random loads and stores against a byte-array model.
`include "mem_defs.svh"

module tb_mem_stage;
    import mem_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;

    logic                   clk;
    logic                   arst_n;
    logic [`DATA_WIDTH-1:0] alu_result;
    logic [`DATA_WIDTH-1:0] write_data;
    logic                   result_src;
    logic                   mem_write;
    logic                   mem_read;
    logic [2:0]             funct3;
    logic [`DATA_WIDTH-1:0] result;
    logic                   stall;

    // Byte image of the whole 1 KiB address space.
    logic [7:0] ref_mem [1024];
    int         seed = 32'h7a6e;
    int         errors;
    int         test_errors;
    int         tests_passed;
    int         tests_failed;
    ls_size_e   store_sizes [3] = '{LS_B, LS_H, LS_W};
    ls_size_e   load_sizes [5] = '{LS_B, LS_H, LS_W, LS_BU, LS_HU};

    mem_stage_top i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .alu_result (alu_result),
        .write_data (write_data),
        .result_src (result_src),
        .mem_write  (mem_write),
        .mem_read   (mem_read),
        .funct3     (funct3),
        .result     (result),
        .stall      (stall)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] ref_load(ls_size_e size, logic [31:0] addr);
        logic [9:0] a;
        a = addr[9:0];
        case (size)
            LS_B:    ref_load = {{24{ref_mem[a][7]}}, ref_mem[a]};
            LS_BU:   ref_load = {24'b0, ref_mem[a]};
            LS_H:    ref_load = {{16{ref_mem[a+10'd1][7]}}, ref_mem[a+10'd1], ref_mem[a]};
            LS_HU:   ref_load = {16'b0, ref_mem[a+10'd1], ref_mem[a]};
            default: ref_load = {ref_mem[a+10'd3], ref_mem[a+10'd2], ref_mem[a+10'd1], ref_mem[a]};
        endcase
    endfunction

    function automatic void ref_store(ls_size_e size, logic [31:0] addr, logic [31:0] data);
        logic [9:0] a;
        a = addr[9:0];
        ref_mem[a] = data[7:0];
        if (size != LS_B) begin
            ref_mem[a+10'd1] = data[15:8];
        end
        if (size == LS_W) begin
            ref_mem[a+10'd2] = data[23:16];
            ref_mem[a+10'd3] = data[31:24];
        end
    endfunction

    task automatic check_load(ls_size_e size, logic [31:0] addr, logic [31:0] got);
        logic [31:0] expected;
        expected = ref_load(size, addr);
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t: %s from %h returned %h, expected %h",
                     $time, size.name(), addr, got, expected);
        end
    endtask

    task automatic check_alu(logic [31:0] expected, logic [31:0] got);
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t: result %h, expected alu_result %h", $time, got, expected);
        end
    endtask

    task automatic check_cycles(int expected, int got, string what);
        if (got != expected) begin
            errors++;
            $display("mismatch at %0t: %s stalled %0d cycles, expected %0d",
                     $time, what, got, expected);
        end
    endtask

    // Drives one request and holds it until stall falls; the result is taken
    // just before the edge that completes the access.
    task automatic do_access(logic rd, logic wr, ls_size_e size, logic [31:0] addr,
                             logic [31:0] data, output logic [31:0] res, output int cycles);
        @(negedge clk);
        mem_read   = rd;
        mem_write  = wr;
        result_src = rd;
        funct3     = size;
        alu_result = addr;
        write_data = data;
        cycles     = 0;
        #1;
        while (stall && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (stall) begin
            errors++;
            $display("timeout at %0t: stall stayed high for %0d cycles on address %h",
                     $time, TIMEOUT_CYCLES, addr);
        end
        res = result;
        @(posedge clk);
        if (wr) begin
            ref_store(size, addr, data);
        end
    endtask

    task automatic write_mem(ls_size_e size, logic [31:0] addr, logic [31:0] data,
                             output int cycles);
        logic [31:0] res;
        do_access(1'b0, 1'b1, size, addr, data, res, cycles);
    endtask

    task automatic read_and_check(ls_size_e size, logic [31:0] addr, output int cycles);
        logic [31:0] res;
        do_access(1'b1, 1'b0, size, addr, 32'h0, res, cycles);
        check_load(size, addr, res);
    endtask

    task automatic report_test(string name);
        if (errors == test_errors) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] r;
        int          cycles;
        ls_size_e    size;

        arst_n       = 1'b0;
        alu_result   = '0;
        write_data   = '0;
        result_src   = 1'b0;
        mem_write    = 1'b0;
        mem_read     = 1'b0;
        funct3       = 3'b010;
        errors       = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        foreach (ref_mem[i]) begin
            ref_mem[i] = 8'h00;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        #1;
        check_cycles(0, stall ? 1 : 0, "idle stage after reset");
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            alu_result = $random(seed);
            #1;
            check_alu(alu_result, result);
        end
        report_test("reset_passthrough");

        write_mem(LS_W, 32'h024, $random(seed), cycles);
        check_cycles(3, cycles, "first store to a line");
        read_and_check(LS_W, 32'h024, cycles);
        check_cycles(0, cycles, "reload of the same word");
        read_and_check(LS_W, 32'h028, cycles);
        check_cycles(0, cycles, "load from the same line");
        report_test("word_access");

        for (int lane = 0; lane < 4; lane++) begin
            data    = $random(seed);
            data[7] = (lane % 2 == 0);
            write_mem(LS_B, 32'h040 + lane, data, cycles);
        end
        for (int lane = 0; lane < 4; lane++) begin
            read_and_check(LS_B, 32'h040 + lane, cycles);
            read_and_check(LS_BU, 32'h040 + lane, cycles);
        end
        read_and_check(LS_W, 32'h040, cycles);
        for (int h = 0; h < 2; h++) begin
            data     = $random(seed);
            data[15] = (h == 0);
            write_mem(LS_H, 32'h044 + 2 * h, data, cycles);
            read_and_check(LS_H, 32'h044 + 2 * h, cycles);
            read_and_check(LS_HU, 32'h044 + 2 * h, cycles);
        end
        read_and_check(LS_W, 32'h044, cycles);
        report_test("subword_access");

        // Same index, tags 0 and 1, on lines no earlier test has touched.
        for (int i = 12; i < 16; i++) begin
            addr = 32'(i * 16);
            write_mem(LS_W, addr, $random(seed), cycles);
            check_cycles(3, cycles, "store to an empty line");
            write_mem(LS_W, addr + 32'h100, $random(seed), cycles);
            check_cycles(4, cycles, "store evicting a dirty line");
            read_and_check(LS_W, addr, cycles);
            check_cycles(4, cycles, "load evicting a dirty line");
            read_and_check(LS_W, addr + 32'h100, cycles);
            check_cycles(3, cycles, "load replacing a clean line");
        end
        report_test("dirty_eviction");

        for (int n = 0; n < 300; n++) begin
            r    = $random(seed);
            data = $random(seed);
            addr = {22'b0, r[9:0]};
            if (r[16]) begin
                size = store_sizes[r[13:12] % 2'd3];
            end else begin
                size = load_sizes[r[14:12] % 3'd5];
            end
            if (size == LS_H || size == LS_HU) begin
                addr[0] = 1'b0;
            end else if (size == LS_W) begin
                addr[1:0] = 2'b00;
            end
            if (r[16]) begin
                write_mem(size, addr, data, cycles);
            end else begin
                read_and_check(size, addr, cycles);
            end
        end
        report_test("random_mix");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== mem_stage_top.sv ====
// Memory stage top: data cache, backing memory and load/store unit behind plain CPU ports.
`include "mem_defs.svh"

module mem_stage_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`DATA_WIDTH-1:0] alu_result,
    input  logic [`DATA_WIDTH-1:0] write_data,
    input  logic                   result_src,
    input  logic                   mem_write,
    input  logic                   mem_read,
    input  logic [2:0]             funct3,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   stall
);
    import mem_pkg::*;

    ls_size_e               size;
    logic                   hit;
    logic                   victim_dirty;
    logic [1:0]             victim_tag;
    logic                   refill_en;
    logic [`DATA_WIDTH-1:0] load_word;
    logic [`DATA_WIDTH-1:0] store_word;
    logic [3:0]             byte_en;

    assign size = ls_size_e'(funct3);

    block_if blk_bus ();

    cache_ctrl i_cache_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .req_addr     (alu_result),
        .victim_tag   (victim_tag),
        .stall        (stall),
        .refill_en    (refill_en),
        .blk          (blk_bus.ctrl)
    );

    cache_array i_cache_array (
        .clk          (clk),
        .arst_n       (arst_n),
        .addr         (alu_result),
        .mem_write    (mem_write),
        .store_word   (store_word),
        .byte_en      (byte_en),
        .refill_en    (refill_en),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .load_word    (load_word),
        .line         (blk_bus.line)
    );

    block_mem i_block_mem (
        .clk (clk),
        .blk (blk_bus.mem)
    );

    load_store_unit i_load_store_unit (
        .alu_result (alu_result),
        .write_data (write_data),
        .funct3     (size),
        .result_src (result_src),
        .load_word  (load_word),
        .store_word (store_word),
        .byte_en    (byte_en),
        .result     (result)
    );

endmodule

// ==== load_store_unit.sv ====
// Load/store unit: store lane placement, load extraction with extension, result select.
`include "mem_defs.svh"

module load_store_unit (
    input  logic [`DATA_WIDTH-1:0] alu_result,
    input  logic [`DATA_WIDTH-1:0] write_data,
    input  mem_pkg::ls_size_e      funct3,
    input  logic                   result_src,
    input  logic [`DATA_WIDTH-1:0] load_word,
    output logic [`DATA_WIDTH-1:0] store_word,
    output logic [3:0]             byte_en,
    output logic [`DATA_WIDTH-1:0] result
);
    import mem_pkg::*;

    logic [1:0]             lane;
    logic [7:0]             load_byte;
    logic [15:0]            load_half;
    logic [`DATA_WIDTH-1:0] load_ext;

    assign lane = alu_result[1:0];

    // Sub-word data is copied to every lane so the enables alone pick the target.
    always_comb begin
        case (funct3)
            LS_B: begin
                store_word = {4{write_data[7:0]}};
                byte_en    = 4'b0001 << lane;
            end
            LS_H: begin
                store_word = {2{write_data[15:0]}};
                byte_en    = lane[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                store_word = write_data;
                byte_en    = 4'b1111;
            end
        endcase
    end

    assign load_byte = load_word[8*lane +: 8];
    assign load_half = load_word[16*lane[1] +: 16];

    always_comb begin
        case (funct3)
            LS_B:    load_ext = {{24{load_byte[7]}}, load_byte};
            LS_BU:   load_ext = {24'b0, load_byte};
            LS_H:    load_ext = {{16{load_half[15]}}, load_half};
            LS_HU:   load_ext = {16'b0, load_half};
            default: load_ext = load_word;
        endcase
    end

    assign result = result_src ? load_ext : alu_result;

endmodule

// ==== block_mem.sv ====
// Backing memory: array of full cache lines with one-cycle synchronous read and write.
`include "mem_defs.svh"

module block_mem (
    input  logic  clk,
    block_if.mem  blk
);

    localparam int LINE_W = `LINE_WORDS * `DATA_WIDTH;

    // Contents start at zero.
    logic [LINE_W-1:0] mem [`MEM_BLOCKS] = '{default: '0};

    always_ff @(posedge clk) begin
        if (blk.wr_en) begin
            mem[blk.blk_addr] <= blk.wdata;
        end
    end

    // Read data appears the cycle after rd_en and holds until the next read.
    always_ff @(posedge clk) begin
        if (blk.rd_en) begin
            blk.rdata <= mem[blk.blk_addr];
        end
    end

endmodule

// ==== cache_array.sv ====
// Data cache array: direct-mapped tags, valid and dirty bits and line data with hit detection.
`include "mem_defs.svh"

module cache_array (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`DATA_WIDTH-1:0] addr,
    input  logic                   mem_write,
    input  logic [`DATA_WIDTH-1:0] store_word,
    input  logic [3:0]             byte_en,
    input  logic                   refill_en,
    output logic                   hit,
    output logic                   victim_dirty,
    output logic [1:0]             victim_tag,
    output logic [`DATA_WIDTH-1:0] load_word,
    block_if.line                  line
);

    localparam int BYTES_W  = $clog2(`DATA_WIDTH / 8);
    localparam int WORD_W   = $clog2(`LINE_WORDS);
    localparam int OFFSET_W = BYTES_W + WORD_W;
    localparam int INDEX_W  = $clog2(`CACHE_LINES);
    localparam int TAG_W    = $clog2(`MEM_BLOCKS) - INDEX_W;

    logic [`CACHE_LINES-1:0]                  valid;
    logic [`CACHE_LINES-1:0]                  dirty;
    logic [TAG_W-1:0]                         tags [`CACHE_LINES];
    logic [`LINE_WORDS-1:0][`DATA_WIDTH-1:0]  data [`CACHE_LINES];

    logic [INDEX_W-1:0]                       index;
    logic [TAG_W-1:0]                         tag;
    logic [WORD_W-1:0]                        word_sel;
    logic [`LINE_WORDS-1:0][`DATA_WIDTH-1:0]  cur_line;
    logic                                     store_hit;

    assign index    = addr[OFFSET_W +: INDEX_W];
    assign tag      = addr[OFFSET_W + INDEX_W +: TAG_W];
    assign word_sel = addr[BYTES_W +: WORD_W];
    assign cur_line = data[index];

    assign hit          = valid[index] && (tags[index] == tag);
    assign victim_dirty = valid[index] && dirty[index];
    assign victim_tag   = tags[index];
    assign load_word    = cur_line[word_sel];

    // The indexed line is always offered as the write-back victim.
    assign line.wdata = cur_line;

    assign store_hit = mem_write && hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
            dirty <= '0;
        end else if (refill_en) begin
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;
        end else if (store_hit) begin
            dirty[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_en) begin
            data[index] <= line.rdata;
            tags[index] <= tag;
        end else if (store_hit) begin
            // Only the enabled byte lanes of the addressed word change.
            for (int b = 0; b < `DATA_WIDTH / 8; b++) begin
                if (byte_en[b]) begin
                    data[index][word_sel][8*b +: 8] <= store_word[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== cache_ctrl.sv ====
// Cache controller: FSM that stalls the CPU and runs write-back and refill on a miss.
`include "mem_defs.svh"

module cache_ctrl (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   mem_read,
    input  logic                   mem_write,
    input  logic                   hit,
    input  logic                   victim_dirty,
    input  logic [`DATA_WIDTH-1:0] req_addr,
    input  logic [1:0]             victim_tag,
    output logic                   stall,
    output logic                   refill_en,
    block_if.ctrl                  blk
);
    import mem_pkg::*;

    localparam int OFFSET_W = $clog2(`LINE_WORDS * `DATA_WIDTH / 8);
    localparam int INDEX_W  = $clog2(`CACHE_LINES);
    localparam int BLOCK_W  = $clog2(`MEM_BLOCKS);

    cache_state_e       state;
    cache_state_e       next_state;
    logic               req;
    logic [INDEX_W-1:0] index;

    assign req   = mem_read | mem_write;
    assign index = req_addr[OFFSET_W +: INDEX_W];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // A dirty victim must reach memory before its line is overwritten.
                if (req && !hit) begin
                    next_state = victim_dirty ? WRITEBACK : REFILL;
                end
            end
            WRITEBACK: next_state = REFILL;
            REFILL:    next_state = FILL;
            FILL:      next_state = IDLE;
        endcase
    end

    always_comb begin
        stall        = 1'b1;
        refill_en    = 1'b0;
        blk.wr_en    = 1'b0;
        blk.rd_en    = 1'b0;
        blk.blk_addr = req_addr[OFFSET_W +: BLOCK_W];
        case (state)
            IDLE: begin
                // The miss is stalled in the same cycle it is seen.
                stall = req && !hit;
            end
            WRITEBACK: begin
                blk.wr_en    = 1'b1;
                blk.blk_addr = {victim_tag, index};
            end
            REFILL: begin
                blk.rd_en = 1'b1;
            end
            FILL: begin
                refill_en = 1'b1;
            end
        endcase
    end

endmodule

// ==== block_if.sv ====
// Line transfer bus: one full cache line moved between the cache and the backing memory.
`include "mem_defs.svh"

interface block_if;

    localparam int LINE_W  = `LINE_WORDS * `DATA_WIDTH;
    localparam int BLOCK_W = $clog2(`MEM_BLOCKS);

    logic [BLOCK_W-1:0] blk_addr;
    logic               wr_en;
    logic               rd_en;
    logic [LINE_W-1:0]  wdata;
    logic [LINE_W-1:0]  rdata;

    // Commands come from the controller.
    modport ctrl (output blk_addr, wr_en, rd_en);

    // The cache array supplies the victim line and takes the refill line.
    modport line (output wdata, input rdata);

    modport mem (input blk_addr, wr_en, rd_en, wdata, output rdata);

endinterface

// ==== mem_pkg.sv ====
// Memory stage types: cache controller states and load/store access sizes.
package mem_pkg;

    // Miss handling sequence of the data cache controller.
    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL,
        FILL
    } cache_state_e;

    // Access size, encoded as the funct3 field of RV32 loads and stores.
    // Stores only use LS_B, LS_H and LS_W.
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_BU = 3'b100,
        LS_HU = 3'b101
    } ls_size_e;

endpackage

// ==== mem_defs.svh ====
// Memory stage geometry: CPU word width, cache line size and count, backing memory depth.
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Width of a CPU word in bits.
`define DATA_WIDTH 32

// Words per cache line, which gives a 128-bit line.
`define LINE_WORDS 4

// Lines in the direct-mapped cache, indexed by address bits 7 to 4.
`define CACHE_LINES 16

// Lines of backing memory, addressed by bits 9 to 4. The tag is bits 9 to 8.
`define MEM_BLOCKS 64

`endif
